//--- hdl/core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;

    // pc increment for the link value of jumps
    localparam int PC_STEP = 4;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // encoded like the branch funct3
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {
        SRC1_RS1  = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1_sel_e;

    typedef enum logic {
        SRC2_RS2 = 1'b0,
        SRC2_IMM = 1'b1
    } src2_sel_e;

    typedef enum logic {
        WB_ALU      = 1'b0,
        WB_PC_PLUS4 = 1'b1
    } wb_sel_e;

    // decoded instruction, held in the ID/EX register
    typedef struct packed {
        logic      valid;
        logic      illegal;
        data_t     pc;
        data_t     rs1_data;
        data_t     rs2_data;
        data_t     imm;
        reg_addr_t rd;
        logic      reg_write;
        logic      jump;
        logic      branch;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        alu_op_e   alu_op;
        cmp_op_e   cmp_op;
        wb_sel_e   wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      illegal;
        reg_addr_t rd;
        logic      reg_write;
        data_t     wb_data;
        logic      redirect;
        data_t     target;
    } ex_result_t;

    // empty slot, every control field inactive
    localparam id_ex_t ID_EX_BUBBLE = '{
        valid:     1'b0,
        illegal:   1'b0,
        pc:        '0,
        rs1_data:  '0,
        rs2_data:  '0,
        imm:       '0,
        rd:        '0,
        reg_write: 1'b0,
        jump:      1'b0,
        branch:    1'b0,
        src1_sel:  SRC1_RS1,
        src2_sel:  SRC2_RS2,
        alu_op:    ALU_ADD,
        cmp_op:    CMP_EQ,
        wb_sel:    WB_ALU
    };

endpackage

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic             valid_i,
    input  core_pkg::data_t  instr_i,
    input  core_pkg::data_t  pc_i,
    input  core_pkg::data_t  rs1_data_i,
    input  core_pkg::data_t  rs2_data_i,
    output core_pkg::id_ex_t bundle_o
);

    core_pkg::opcode_e   opcode;
    logic [2:0]          funct3;
    logic                funct7_alt;
    core_pkg::reg_addr_t rd;
    core_pkg::data_t     imm_i;
    core_pkg::data_t     imm_b;
    core_pkg::data_t     imm_u;
    core_pkg::data_t     imm_j;
    core_pkg::alu_op_e   arith_op;
    core_pkg::cmp_op_e   cmp_op;
    logic                rd_write;

    assign opcode     = core_pkg::opcode_e'(instr_i[6:0]);
    assign funct3     = instr_i[14:12];
    assign funct7_alt = instr_i[30];
    assign rd         = instr_i[11:7];

    // immediates sign extended from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // sub only exists in register form and srai carries bit 30 in its immediate
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == core_pkg::OPC_OP && funct7_alt) ?
                                core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  arith_op = core_pkg::ALU_SLL;
            3'b010:  arith_op = core_pkg::ALU_SLT;
            3'b011:  arith_op = core_pkg::ALU_SLTU;
            3'b100:  arith_op = core_pkg::ALU_XOR;
            3'b101:  arith_op = funct7_alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  arith_op = core_pkg::ALU_OR;
            default: arith_op = core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  cmp_op = core_pkg::CMP_EQ;
            3'b001:  cmp_op = core_pkg::CMP_NE;
            3'b100:  cmp_op = core_pkg::CMP_LT;
            3'b101:  cmp_op = core_pkg::CMP_GE;
            3'b110:  cmp_op = core_pkg::CMP_LTU;
            default: cmp_op = core_pkg::CMP_GEU;
        endcase
    end

    always_comb begin
        bundle_o          = core_pkg::ID_EX_BUBBLE;
        bundle_o.valid    = valid_i;
        bundle_o.pc       = pc_i;
        bundle_o.rs1_data = rs1_data_i;
        bundle_o.rs2_data = rs2_data_i;
        bundle_o.rd       = rd;
        rd_write          = 1'b1;
        case (opcode)
            core_pkg::OPC_OP: begin
                bundle_o.alu_op = arith_op;
            end
            core_pkg::OPC_OP_IMM: begin
                bundle_o.src2_sel = core_pkg::SRC2_IMM;
                bundle_o.imm      = imm_i;
                bundle_o.alu_op   = arith_op;
            end
            core_pkg::OPC_LUI, core_pkg::OPC_AUIPC: begin
                bundle_o.src1_sel = (opcode == core_pkg::OPC_LUI) ?
                                    core_pkg::SRC1_ZERO : core_pkg::SRC1_PC;
                bundle_o.src2_sel = core_pkg::SRC2_IMM;
                bundle_o.imm      = imm_u;
            end
            core_pkg::OPC_JAL, core_pkg::OPC_JALR: begin
                // alu forms the target while writeback takes the link address
                bundle_o.src1_sel = (opcode == core_pkg::OPC_JAL) ?
                                    core_pkg::SRC1_PC : core_pkg::SRC1_RS1;
                bundle_o.src2_sel = core_pkg::SRC2_IMM;
                bundle_o.imm      = (opcode == core_pkg::OPC_JAL) ? imm_j : imm_i;
                bundle_o.jump     = 1'b1;
                bundle_o.wb_sel   = core_pkg::WB_PC_PLUS4;
            end
            core_pkg::OPC_BRANCH: begin
                bundle_o.src1_sel = core_pkg::SRC1_PC;
                bundle_o.src2_sel = core_pkg::SRC2_IMM;
                bundle_o.imm      = imm_b;
                bundle_o.branch   = 1'b1;
                bundle_o.cmp_op   = cmp_op;
                bundle_o.rd       = '0;
                rd_write          = 1'b0;
            end
            default: begin
                bundle_o.illegal = 1'b1;
                rd_write         = 1'b0;
            end
        endcase
        bundle_o.reg_write = rd_write && (bundle_o.rd != '0);
        // a bubble carries no side effects
        if (!valid_i) begin
            bundle_o.illegal   = 1'b0;
            bundle_o.reg_write = 1'b0;
            bundle_o.jump      = 1'b0;
            bundle_o.branch    = 1'b0;
        end
    end

endmodule

//--- hdl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             kill_i,
    input  core_pkg::id_ex_t bundle_i,
    output core_pkg::id_ex_t bundle_o
);

    // whole bundle as one register, a bubble on reset, flush or kill
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bundle_o <= core_pkg::ID_EX_BUBBLE;
        end else if (flush_i || kill_i) begin
            // wrong-path or flushed slot
            bundle_o <= core_pkg::ID_EX_BUBBLE;
        end else begin
            bundle_o <= bundle_i;
        end
    end

    // kill comes back from the execute stage through ex_combine
    a_clear_after_flush_or_kill : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (flush_i || kill_i) |=> !bundle_o.valid
    ) else $error("id_ex_reg: valid slot after flush or kill");

    // a bubble must never reach execute with side effects
    a_bubble_is_inert : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !bundle_o.valid |-> !(bundle_o.reg_write || bundle_o.jump || bundle_o.branch)
    ) else $error("id_ex_reg: bubble with active control");

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  core_pkg::id_ex_t bundle_i,
    output core_pkg::data_t  result_o
);

    core_pkg::data_t op_a;
    core_pkg::data_t op_b;
    logic [4:0]      shamt;

    // first operand, pc for auipc, jal and branch targets
    always_comb begin
        case (bundle_i.src1_sel)
            core_pkg::SRC1_PC:   op_a = bundle_i.pc;
            core_pkg::SRC1_ZERO: op_a = '0;
            default:             op_a = bundle_i.rs1_data;
        endcase
    end

    assign op_b  = (bundle_i.src2_sel == core_pkg::SRC2_IMM) ? bundle_i.imm : bundle_i.rs2_data;
    assign shamt = op_b[4:0];

    // jump and branch targets come out of the add path
    always_comb begin
        case (bundle_i.alu_op)
            core_pkg::ALU_SUB:  result_o = op_a - op_b;
            core_pkg::ALU_SLL:  result_o = op_a << shamt;
            core_pkg::ALU_SLT:  result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            core_pkg::ALU_SLTU: result_o = {31'b0, op_a < op_b};
            core_pkg::ALU_XOR:  result_o = op_a ^ op_b;
            core_pkg::ALU_SRL:  result_o = op_a >> shamt;
            core_pkg::ALU_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
            core_pkg::ALU_OR:   result_o = op_a | op_b;
            core_pkg::ALU_AND:  result_o = op_a & op_b;
            default:            result_o = op_a + op_b;
        endcase
    end

endmodule

//--- hdl/branch_cmp.sv
`timescale 1ns/1ps

module branch_cmp (
    input  core_pkg::id_ex_t bundle_i,
    output logic             taken_o
);

    logic cond;
    logic is_eq;
    logic is_lt;
    logic is_ltu;

    assign is_eq  = bundle_i.rs1_data == bundle_i.rs2_data;
    assign is_lt  = $signed(bundle_i.rs1_data) < $signed(bundle_i.rs2_data);
    assign is_ltu = bundle_i.rs1_data < bundle_i.rs2_data;

    always_comb begin
        case (bundle_i.cmp_op)
            core_pkg::CMP_NE:  cond = !is_eq;
            core_pkg::CMP_LT:  cond = is_lt;
            core_pkg::CMP_GE:  cond = !is_lt;
            core_pkg::CMP_LTU: cond = is_ltu;
            core_pkg::CMP_GEU: cond = !is_ltu;
            default:           cond = is_eq;
        endcase
    end

    // only a real branch may report taken
    assign taken_o = bundle_i.valid && bundle_i.branch && cond;

endmodule

//--- hdl/ex_combine.sv
`timescale 1ns/1ps

module ex_combine (
    input  core_pkg::id_ex_t     bundle_i,
    input  core_pkg::data_t      alu_result_i,
    input  logic                 taken_i,
    output core_pkg::ex_result_t ex_o,
    output logic                 kill_o
);

    core_pkg::data_t pc_plus4;
    logic            redirect;

    assign pc_plus4 = bundle_i.pc + core_pkg::data_t'(core_pkg::PC_STEP);

    // taken_i already carries the valid qualifier
    assign redirect = (bundle_i.valid && bundle_i.jump) || taken_i;

    always_comb begin
        ex_o.valid     = bundle_i.valid;
        ex_o.illegal   = bundle_i.illegal;
        ex_o.rd        = bundle_i.rd;
        ex_o.reg_write = bundle_i.reg_write;
        ex_o.wb_data   = (bundle_i.wb_sel == core_pkg::WB_PC_PLUS4) ? pc_plus4 : alu_result_i;
        ex_o.redirect  = redirect;
        // jalr needs bit 0 cleared, harmless for the others
        ex_o.target    = {alu_result_i[core_pkg::XLEN-1:1], 1'b0};
        assert (!redirect || bundle_i.valid)
            else $error("ex_combine: redirect from a bubble");
    end

    // drop the wrong-path follower in id_ex_reg
    assign kill_o = redirect;

endmodule

//--- hdl/decode_execute_top.sv
`timescale 1ns/1ps

module decode_execute_top (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 valid_i,
    input  logic                 flush_i,
    input  core_pkg::data_t      instr_i,
    input  core_pkg::data_t      pc_i,
    input  core_pkg::data_t      rs1_data_i,
    input  core_pkg::data_t      rs2_data_i,
    output core_pkg::ex_result_t ex_o
);

    core_pkg::id_ex_t dec_bundle;
    core_pkg::id_ex_t ex_bundle;
    core_pkg::data_t  alu_result;
    logic             cmp_true;
    logic             kill;

    instr_decoder u_decoder (
        .valid_i    (valid_i),
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .bundle_o   (dec_bundle)
    );

    id_ex_reg u_id_ex (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .kill_i   (kill),
        .bundle_i (dec_bundle),
        .bundle_o (ex_bundle)
    );

    // execute stage, all combinational
    alu u_alu (
        .bundle_i (ex_bundle),
        .result_o (alu_result)
    );

    branch_cmp u_cmp (
        .bundle_i (ex_bundle),
        .taken_o  (cmp_true)
    );

    ex_combine u_combine (
        .bundle_i     (ex_bundle),
        .alu_result_i (alu_result),
        .taken_i      (cmp_true),
        .ex_o         (ex_o),
        .kill_o       (kill)
    );

endmodule

//--- verif/tb_vectors.svh
    // columns: instr, pc, rs1 data, rs2 data, flush, expected ex_o
    // a row after a taken redirect or with flush set expects a bubble
    task automatic fill_table();
        vt[0]  = '{enc_r(7'h00, 3'd0, 5'd3), 32'h100, 32'd5, 32'd7, 1'b0,
                   writes(5'd3, 32'd12)};
        vt[1]  = '{enc_r(7'h20, 3'd0, 5'd4), 32'h104, 32'd5, 32'd7, 1'b0,
                   writes(5'd4, 32'hffff_fffe)};
        vt[2]  = '{enc_r(7'h00, 3'd2, 5'd5), 32'h108, 32'hffff_ffff, 32'd1, 1'b0,
                   writes(5'd5, 32'd1)};
        vt[3]  = '{enc_r(7'h00, 3'd3, 5'd6), 32'h10c, 32'hffff_ffff, 32'd1, 1'b0,
                   writes(5'd6, 32'd0)};
        vt[4]  = '{enc_r(7'h20, 3'd5, 5'd7), 32'h110, 32'h8000_0000, 32'd4, 1'b0,
                   writes(5'd7, 32'hf800_0000)};
        vt[5]  = '{enc_i(12'hfff, 3'd0, 5'd9, 7'h13), 32'h114, 32'd10, 32'h0, 1'b0,
                   writes(5'd9, 32'd9)};
        vt[6]  = '{enc_i(12'h404, 3'd5, 5'd10, 7'h13), 32'h118, 32'h8000_0010, 32'h0, 1'b0,
                   writes(5'd10, 32'hf800_0001)};
        vt[7]  = '{enc_i(12'hfff, 3'd3, 5'd11, 7'h13), 32'h11c, 32'd5, 32'h0, 1'b0,
                   writes(5'd11, 32'd1)};
        vt[8]  = '{enc_u(20'h12345, 5'd13, 7'h37), 32'h120, 32'h0, 32'h0, 1'b0,
                   writes(5'd13, 32'h1234_5000)};
        vt[9]  = '{enc_u(20'h00001, 5'd14, 7'h17), 32'h124, 32'h0, 32'h0, 1'b0,
                   writes(5'd14, 32'h0000_1124)};
        // write to x0 is dropped
        vt[10] = '{enc_r(7'h00, 3'd0, 5'd0), 32'h128, 32'd5, 32'd7, 1'b0, no_write()};
        vt[11] = '{enc_b(13'd16, 3'd0), 32'h12c, 32'd1, 32'd2, 1'b0, no_write()};
        vt[12] = '{enc_b(13'h1ff8, 3'd4), 32'h130, 32'hffff_ffff, 32'd1, 1'b0,
                   taken(32'h128)};
        vt[13] = '{enc_r(7'h00, 3'd0, 5'd3), 32'h134, 32'd5, 32'd7, 1'b0, bubble()};
        vt[14] = '{enc_b(13'd32, 3'd7), 32'h138, 32'd1, 32'hffff_ffff, 1'b0, no_write()};
        vt[15] = '{enc_b(13'd64, 3'd1), 32'h13c, 32'd3, 32'd4, 1'b0, taken(32'h17c)};
        vt[16] = '{enc_r(7'h00, 3'd0, 5'd3), 32'h140, 32'd5, 32'd7, 1'b0, bubble()};
        vt[17] = '{enc_j(21'h100, 5'd1), 32'h144, 32'h0, 32'h0, 1'b0,
                   jumps(5'd1, 32'h148, 32'h244)};
        vt[18] = '{enc_r(7'h00, 3'd0, 5'd3), 32'h148, 32'd5, 32'd7, 1'b0, bubble()};
        vt[19] = '{enc_i(12'd5, 3'd0, 5'd5, 7'h67), 32'h14c, 32'h1000, 32'h0, 1'b0,
                   jumps(5'd5, 32'h150, 32'h1004)};
        vt[20] = '{enc_r(7'h00, 3'd0, 5'd3), 32'h150, 32'd5, 32'd7, 1'b0, bubble()};
        vt[21] = '{enc_r(7'h00, 3'd0, 5'd3), 32'h154, 32'd5, 32'd7, 1'b1, bubble()};
        // lw x3 is outside the subset
        vt[22] = '{32'h0000_a183, 32'h158, 32'h0, 32'h0, 1'b0, illegal_op()};
        vt[23] = '{enc_r(7'h00, 3'd4, 5'd15), 32'h15c, 32'hff00_ff00, 32'h0ff0_0ff0, 1'b0,
                   writes(5'd15, 32'hf0f0_f0f0)};
    endtask

//--- verif/tb_decode_execute.sv
`timescale 1ns/1ps

module tb_decode_execute;

    localparam int VEC_COUNT  = 24;
    localparam int RAND_COUNT = 64;
    // reset, directed table, random phase and margin
    localparam int CYCLE_LIMIT = 2 + VEC_COUNT + RAND_COUNT + 20;

    typedef struct packed {
        core_pkg::data_t      instr;
        core_pkg::data_t      pc;
        core_pkg::data_t      rs1;
        core_pkg::data_t      rs2;
        logic                 flush;
        core_pkg::ex_result_t expected;
    } vec_t;

    logic                 clk;
    logic                 rst_n_i;
    logic                 valid_i;
    logic                 flush_i;
    core_pkg::data_t      instr_i;
    core_pkg::data_t      pc_i;
    core_pkg::data_t      rs1_data_i;
    core_pkg::data_t      rs2_data_i;
    core_pkg::ex_result_t ex_o;

    vec_t        vt [VEC_COUNT];
    logic [31:0] rng_state;
    int          cycles = 0;

    decode_execute_top UUT (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .valid_i    (valid_i),
        .flush_i    (flush_i),
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .ex_o       (ex_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("sim failed");
            $fatal(1, "timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    // RV32I instruction formats, source registers fixed to x1 and x2
    function automatic core_pkg::data_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::data_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic core_pkg::data_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                              input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic core_pkg::data_t enc_b(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic core_pkg::data_t enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // expected results by instruction class
    function automatic core_pkg::ex_result_t writes(input core_pkg::reg_addr_t rd,
                                                    input core_pkg::data_t wb);
        return '{1'b1, 1'b0, rd, 1'b1, wb, 1'b0, 32'h0};
    endfunction

    function automatic core_pkg::ex_result_t no_write();
        return '{1'b1, 1'b0, 5'd0, 1'b0, 32'h0, 1'b0, 32'h0};
    endfunction

    function automatic core_pkg::ex_result_t taken(input core_pkg::data_t tgt);
        return '{1'b1, 1'b0, 5'd0, 1'b0, 32'h0, 1'b1, tgt};
    endfunction

    function automatic core_pkg::ex_result_t jumps(input core_pkg::reg_addr_t rd,
                                                   input core_pkg::data_t wb,
                                                   input core_pkg::data_t tgt);
        return '{1'b1, 1'b0, rd, 1'b1, wb, 1'b1, tgt};
    endfunction

    function automatic core_pkg::ex_result_t bubble();
        return '0;
    endfunction

    function automatic core_pkg::ex_result_t illegal_op();
        return '{1'b1, 1'b1, 5'd0, 1'b0, 32'h0, 1'b0, 32'h0};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    `include "tb_vectors.svh"

    task automatic compare_field(input string name, input string what,
                                 input core_pkg::data_t exp_v, input core_pkg::data_t act_v);
        if (act_v !== exp_v) begin
            $display("** Error: %s %s expected 0x%08h actual 0x%08h", name, what, exp_v, act_v);
            $display("sim failed");
            $fatal(1, "%s: wrong %s", name, what);
        end
    endtask

    task automatic check_result(input string name, input core_pkg::ex_result_t exp_r,
                                input core_pkg::ex_result_t act_r);
        compare_field(name, "valid", 32'(exp_r.valid), 32'(act_r.valid));
        compare_field(name, "illegal", 32'(exp_r.illegal), 32'(act_r.illegal));
        compare_field(name, "reg_write", 32'(exp_r.reg_write), 32'(act_r.reg_write));
        if (exp_r.reg_write) begin
            compare_field(name, "rd", 32'(exp_r.rd), 32'(act_r.rd));
            compare_field(name, "wb_data", exp_r.wb_data, act_r.wb_data);
        end
    endtask

    task automatic check_redirect(input string name, input core_pkg::ex_result_t exp_r,
                                  input core_pkg::ex_result_t act_r);
        compare_field(name, "redirect", 32'(exp_r.redirect), 32'(act_r.redirect));
        if (exp_r.redirect)
            compare_field(name, "target", exp_r.target, act_r.target);
    endtask

    task automatic check_bubble(input string name, input core_pkg::ex_result_t act_r);
        compare_field(name, "valid", 32'd0, 32'(act_r.valid));
        compare_field(name, "redirect", 32'd0, 32'(act_r.redirect));
        compare_field(name, "reg_write", 32'd0, 32'(act_r.reg_write));
    endtask

    task automatic drive(input logic v, input logic fl, input core_pkg::data_t ins,
                         input core_pkg::data_t pc, input core_pkg::data_t a,
                         input core_pkg::data_t b);
        valid_i    = v;
        flush_i    = fl;
        instr_i    = ins;
        pc_i       = pc;
        rs1_data_i = a;
        rs2_data_i = b;
    endtask

    initial begin
        string                name;
        core_pkg::data_t      a;
        core_pkg::data_t      b;
        core_pkg::data_t      want;
        core_pkg::reg_addr_t  rd;
        logic [1:0]           pick;
        logic [2:0]           f3;
        logic [6:0]           f7;
        clk       = 1'b0;
        rst_n_i   = 1'b0;
        rng_state = 32'h58866d6c;
        drive(1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 32'h0);
        fill_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(posedge clk);
        #1;
        check_bubble("after reset", ex_o);

        // one entry per cycle, its result is on ex_o after the next edge
        for (int i = 0; i < VEC_COUNT; i++) begin
            drive(1'b1, vt[i].flush, vt[i].instr, vt[i].pc, vt[i].rs1, vt[i].rs2);
            @(posedge clk);
            #1;
            name = $sformatf("vector %0d", i);
            if (vt[i].expected.valid) begin
                check_result(name, vt[i].expected, ex_o);
                check_redirect(name, vt[i].expected, ex_o);
            end else begin
                check_bubble(name, ex_o);
            end
        end

        // random add, sub, xor and sltu on register operands
        for (int i = 0; i < RAND_COUNT; i++) begin
            rng_state = xorshift32(rng_state);
            a = rng_state;
            rng_state = xorshift32(rng_state);
            b = rng_state;
            rng_state = xorshift32(rng_state);
            pick = rng_state[1:0];
            rd   = rng_state[6:2] | 5'd1;
            case (pick)
                2'd0:    want = a + b;
                2'd1:    want = a - b;
                2'd2:    want = a ^ b;
                default: want = {31'b0, a < b};
            endcase
            f3 = (pick == 2'd2) ? 3'd4 : ((pick == 2'd3) ? 3'd3 : 3'd0);
            f7 = (pick == 2'd1) ? 7'h20 : 7'h00;
            drive(1'b1, 1'b0, enc_r(f7, f3, rd), 32'h1000 + 32'(i) * 32'd4, a, b);
            @(posedge clk);
            #1;
            name = $sformatf("random %0d", i);
            check_result(name, writes(rd, want), ex_o);
            check_redirect(name, writes(rd, want), ex_o);
        end

        $display("sim passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+verif
hdl/core_pkg.sv
hdl/instr_decoder.sv
hdl/id_ex_reg.sv
hdl/alu.sv
hdl/branch_cmp.sv
hdl/ex_combine.sv
hdl/decode_execute_top.sv
verif/tb_decode_execute.sv

//--- Makefile
SIM  := obj_dir/Vtb_decode_execute
SRCS := $(shell grep -v '^+' sources.f) $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when the file list, a source or the vector table changes
$(SIM): sources.f $(SRCS)
	verilator --binary --assert --top-module tb_decode_execute \
		-f sources.f -Mdir obj_dir

# the exit status of the binary is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
